//--- design/access_align.sv
`timescale 1ns/1ps

module access_align import dcache_pkg::*; (
    input  line_t     line_in,
    input  word_off_t word_off,
    input  byte_off_t byte_off,
    input  funct3_t   funct3,
    input  word_t     store_data,
    output word_t     load_data,
    output line_t     merged_line
);

    word_t      word_sel;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic [6:0] bit_pos;

    // Bit position of the addressed byte inside the line
    assign bit_pos  = {word_off, byte_off, 3'b000};
    assign word_sel = line_in[{word_off, 5'b00000} +: 32];
    assign byte_sel = word_sel[{byte_off, 3'b000} +: 8];
    // Halfwords are aligned, so byte_off is 0 or 2 here
    assign half_sel = word_sel[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{byte_sel[7]}}, byte_sel};
            F3_H:    load_data = {{16{half_sel[15]}}, half_sel};
            F3_BU:   load_data = {24'h000000, byte_sel};
            F3_HU:   load_data = {16'h0000, half_sel};
            default: load_data = word_sel;
        endcase
    end

    // Replace only the bytes that the store covers
    always_comb begin
        merged_line = line_in;
        case (funct3)
            F3_B: begin
                merged_line[bit_pos +: 8] = store_data[7:0];
            end
            F3_H: begin
                merged_line[{word_off, byte_off[1], 4'b0000} +: 16] = store_data[15:0];
            end
            default: begin
                merged_line[{word_off, 5'b00000} +: 32] = store_data;
            end
        endcase
    end

endmodule

//--- design/dcache_array.sv
`timescale 1ns/1ps

module dcache_array import dcache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t addr,
    input  logic  lookup_en,
    output logic  hit,
    output line_t hit_line,
    output way_t  victim_way,
    output logic  victim_valid,
    output logic  victim_dirty,
    output tag_t  victim_tag,
    output line_t victim_line,
    input  logic  store_en,
    input  line_t store_line,
    input  logic  fill_en,
    input  line_t fill_line,
    input  logic  clean_en
);

    line_t data  [NUM_SETS][NUM_WAYS];
    tag_t  tags  [NUM_SETS][NUM_WAYS];
    logic  valid [NUM_SETS][NUM_WAYS];
    logic  dirty [NUM_SETS][NUM_WAYS];
    way_t  lru   [NUM_SETS];

    tag_t                req_tag;
    set_idx_t            set_idx;
    logic [NUM_WAYS-1:0] match;
    way_t                hit_way;

    assign req_tag = addr[31:5];
    assign set_idx = addr[4];

    // Both ways compared in parallel
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid[set_idx][w] && (tags[set_idx][w] == req_tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit      = lookup_en && (|match);
    assign hit_line = data[set_idx][hit_way];

    // LRU points at the way to replace next
    assign victim_way   = lru[set_idx];
    assign victim_valid = valid[set_idx][victim_way];
    assign victim_dirty = dirty[set_idx][victim_way];
    assign victim_tag   = tags[set_idx][victim_way];
    assign victim_line  = data[set_idx][victim_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
                lru[s] <= '0;
            end
        end else begin
            if (fill_en) begin
                // A store merged into the refill leaves the line dirty
                valid[set_idx][victim_way] <= 1'b1;
                dirty[set_idx][victim_way] <= store_en;
                lru[set_idx]               <= ~victim_way;
            end else if (store_en) begin
                dirty[set_idx][hit_way] <= 1'b1;
                lru[set_idx]            <= ~hit_way;
            end else if (clean_en) begin
                dirty[set_idx][victim_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data[set_idx][victim_way] <= fill_line;
            tags[set_idx][victim_way] <= req_tag;
        end else if (store_en) begin
            data[set_idx][hit_way] <= store_line;
        end
    end

endmodule

//--- design/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     read_en,
    input  logic     write_en,
    input  logic     bypass,
    input  addr_t    addr,
    input  word_t    write_data,
    input  funct3_t  funct3,
    input  logic     hit,
    input  logic     victim_valid,
    input  logic     victim_dirty,
    input  tag_t     victim_tag,
    input  line_t    victim_line,
    input  logic     mem_ready,
    input  line_t    mem_read_data,
    input  line_t    merged_line,
    output logic     busy,
    output logic     lookup_en,
    output logic     store_en,
    output line_t    store_line,
    output logic     fill_en,
    output line_t    fill_line,
    output logic     clean_en,
    output logic     refill_sel,
    output mem_req_t mem_req,
    output word_t    align_data,
    output funct3_t  align_funct3
);

    ctrl_state_t state;

    logic     pend_store;
    word_t    pend_data;
    funct3_t  pend_funct3;
    set_idx_t set_idx;
    addr_t    line_addr;
    logic     miss;
    logic     refill_done;

    assign set_idx   = addr[4];
    assign line_addr = {addr[31:5], set_idx, 4'b0000};

    // Bypassed loads never touch the cache
    assign lookup_en = (read_en && !bypass) || write_en;
    assign busy      = lookup_en && !hit;
    assign miss      = busy && (state == IDLE);

    assign refill_done = (state == REFILL) && mem_ready;
    assign refill_sel  = (state == REFILL);
    assign clean_en    = (state == WRITEBACK) && mem_ready;
    assign fill_en     = refill_done;

    // Store hit in IDLE, or a pending store merged at refill
    assign store_en   = ((state == IDLE) && write_en && hit) || (refill_done && pend_store);
    assign store_line = merged_line;
    assign fill_line  = pend_store ? merged_line : mem_read_data;

    assign align_data   = (state == IDLE) ? write_data : pend_data;
    assign align_funct3 = (state == IDLE) ? funct3 : pend_funct3;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            mem_req    <= '0;
            pend_store <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        pend_store <= write_en;
                        if (victim_valid && victim_dirty) begin
                            mem_req.write_en   <= 1'b1;
                            mem_req.addr       <= {victim_tag, set_idx, 4'b0000};
                            mem_req.write_data <= victim_line;
                            state              <= WRITEBACK;
                        end else begin
                            mem_req.read_en <= 1'b1;
                            mem_req.addr    <= line_addr;
                            state           <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    // Victim is in memory, fetch the missing line next
                    if (mem_ready) begin
                        mem_req.write_en <= 1'b0;
                        mem_req.read_en  <= 1'b1;
                        mem_req.addr     <= line_addr;
                        state            <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_ready) begin
                        mem_req.read_en <= 1'b0;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Store payload held for the merge at refill
    always_ff @(posedge clk) begin
        if (miss) begin
            pend_data   <= write_data;
            pend_funct3 <= funct3;
        end
    end

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int NUM_SETS = 2;
    localparam int NUM_WAYS = 2;

    // Backing memory, indexed by address bits 7 to 4
    localparam int MEM_LINES    = 16;
    localparam int MEM_LATENCY  = 4;
    localparam int MEM_IDX_BITS = $clog2(MEM_LINES);
    localparam int MEM_CNT_BITS = $clog2(MEM_LATENCY) + 1;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;

    // Address split: tag | set | word | byte
    typedef logic [26:0] tag_t;
    typedef logic        set_idx_t;
    typedef logic        way_t;
    typedef logic [1:0]  word_off_t;
    typedef logic [1:0]  byte_off_t;

    // Access size and sign, as in the RISC-V funct3 field
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

    // Line-wide request to the backing memory
    typedef struct packed {
        logic  read_en;
        logic  write_en;
        addr_t addr;
        line_t write_data;
    } mem_req_t;

endpackage

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  addr_t   addr,
    input  word_t   write_data,
    input  logic    write_en,
    input  logic    read_en,
    input  logic    bypass,
    input  funct3_t funct3,
    output word_t   read_data,
    output logic    hit,
    output logic    busy
);

    line_t    hit_line;
    logic     victim_valid;
    logic     victim_dirty;
    tag_t     victim_tag;
    line_t    victim_line;
    logic     lookup_en;
    logic     store_en;
    line_t    store_line;
    logic     fill_en;
    line_t    fill_line;
    logic     clean_en;
    logic     refill_sel;
    mem_req_t mem_req;
    logic     mem_ready;
    line_t    mem_read_data;
    line_t    align_line;
    line_t    merged_line;
    word_t    align_data;
    funct3_t  align_funct3;

    // During refill the merger works on the line coming from memory
    assign align_line = refill_sel ? mem_read_data : hit_line;

    dcache_array array_i (
        .clk          (clk),
        .reset        (reset),
        .addr         (addr),
        .lookup_en    (lookup_en),
        .hit          (hit),
        .hit_line     (hit_line),
        .victim_way   (),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .store_en     (store_en),
        .store_line   (store_line),
        .fill_en      (fill_en),
        .fill_line    (fill_line),
        .clean_en     (clean_en)
    );

    dcache_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .read_en       (read_en),
        .write_en      (write_en),
        .bypass        (bypass),
        .addr          (addr),
        .write_data    (write_data),
        .funct3        (funct3),
        .hit           (hit),
        .victim_valid  (victim_valid),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .mem_ready     (mem_ready),
        .mem_read_data (mem_read_data),
        .merged_line   (merged_line),
        .busy          (busy),
        .lookup_en     (lookup_en),
        .store_en      (store_en),
        .store_line    (store_line),
        .fill_en       (fill_en),
        .fill_line     (fill_line),
        .clean_en      (clean_en),
        .refill_sel    (refill_sel),
        .mem_req       (mem_req),
        .align_data    (align_data),
        .align_funct3  (align_funct3)
    );

    access_align align_i (
        .line_in     (align_line),
        .word_off    (addr[3:2]),
        .byte_off    (addr[1:0]),
        .funct3      (align_funct3),
        .store_data  (align_data),
        .load_data   (read_data),
        .merged_line (merged_line)
    );

    line_memory mem_i (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .mem_read_data (mem_read_data)
    );

endmodule

//--- design/line_memory.sv
`timescale 1ns/1ps

module line_memory import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output logic     mem_ready,
    output line_t    mem_read_data
);

    line_t mem [MEM_LINES];

    logic                    active;
    logic [MEM_CNT_BITS-1:0] count;
    logic [MEM_IDX_BITS-1:0] idx;
    logic                    req_on;
    logic                    last;

    assign idx    = mem_req.addr[MEM_IDX_BITS+3:4];
    assign req_on = mem_req.read_en || mem_req.write_en;
    assign last   = active && (count == 1);

    // A request still high during its ready cycle is not a new one
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            count     <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if (active) begin
                count <= count - 1'b1;
                if (last) begin
                    mem_ready <= 1'b1;
                    active    <= 1'b0;
                end
            end else if (req_on && !mem_ready) begin
                active <= 1'b1;
                count  <= MEM_CNT_BITS'(MEM_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last) begin
            if (mem_req.write_en) begin
                mem[idx] <= mem_req.write_data;
            end
            mem_read_data <= mem[idx];
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output="$(./obj_dir/Vdcache_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- sources.f
design/dcache_pkg.sv
design/access_align.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/line_memory.sv
design/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

//--- tb/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker import dcache_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     hit,
    input logic     busy,
    input mem_req_t mem_req,
    input logic     mem_ready
);

    int unsigned fail_count;

    initial fail_count = 0;

    // One memory transfer at a time
    one_enable: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read_en && mem_req.write_en))
        else begin
            fail_count++;
            $error("memory read and write enables high together");
        end

    // Request held with a stable address until ready
    read_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req.read_en && !mem_ready) |=> (mem_req.read_en && $stable(mem_req.addr)))
        else begin
            fail_count++;
            $error("memory read request dropped or moved before ready");
        end

    write_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req.write_en && !mem_ready) |=> (mem_req.write_en && $stable(mem_req.addr)))
        else begin
            fail_count++;
            $error("memory write request dropped or moved before ready");
        end

    // A hit never overlaps a memory transfer
    hit_no_transfer: assert property (@(posedge clk) disable iff (reset)
        hit |-> (!mem_req.read_en && !mem_req.write_en))
        else begin
            fail_count++;
            $error("hit while a memory transfer is in flight");
        end

    // Quiet first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |-> (!busy && !mem_req.read_en && !mem_req.write_en))
        else begin
            fail_count++;
            $error("busy or a memory enable high right after reset");
        end

endmodule

bind dcache_top dcache_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .hit       (hit),
    .busy      (busy),
    .mem_req   (mem_req),
    .mem_ready (mem_ready)
);

//--- tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    logic    clk;
    logic    reset;
    addr_t   addr;
    word_t   write_data;
    logic    write_en;
    logic    read_en;
    logic    bypass;
    funct3_t funct3;
    word_t   read_data;
    logic    hit;
    logic    busy;

    // Byte-level reference of everything stored
    logic [7:0]  model_bytes [256];
    logic        model_valid [256];
    int unsigned errors;
    logic        hung;
    addr_t       hang_addr;
    word_t       rd;
    logic        first_hit;
    logic        first_busy;

    dcache_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .write_data (write_data),
        .write_en   (write_en),
        .read_en    (read_en),
        .bypass     (bypass),
        .funct3     (funct3),
        .read_data  (read_data),
        .hit        (hit),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        wait (hung === 1'b1);
        $display("busy never cleared within 50 cycles, access at address %h", hang_addr);
        $display("tests failed");
        $finish;
    end

    function automatic int access_bytes(input funct3_t f3);
        case (f3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    // Load result from raw little-endian bytes
    function automatic word_t extend(input word_t raw, input funct3_t f3);
        case (f3)
            F3_B:    return {{24{raw[7]}}, raw[7:0]};
            F3_H:    return {{16{raw[15]}}, raw[15:0]};
            F3_BU:   return {24'h000000, raw[7:0]};
            F3_HU:   return {16'h0000, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic funct3_t kind_of(input int unsigned k);
        case (k)
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    task automatic check_flag(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            errors++;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after completion
    task automatic access(input logic store_op, input logic byp, input addr_t a,
                          input funct3_t f3, input word_t wd);
        int cycles;
        addr       = a;
        funct3     = f3;
        write_data = wd;
        write_en   = store_op;
        read_en    = !store_op;
        bypass     = byp;
        #1;
        first_hit  = hit;
        first_busy = busy;
        cycles     = 0;
        while (busy && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            hang_addr = a;
            hung      = 1'b1;
            forever @(negedge clk);
        end else begin
            rd = read_data;
            @(negedge clk);
            write_en = 1'b0;
            read_en  = 1'b0;
            bypass   = 1'b0;
        end
    endtask

    task automatic store(input addr_t a, input funct3_t f3, input word_t wd);
        access(1'b1, 1'b0, a, f3, wd);
        for (int i = 0; i < access_bytes(f3); i++) begin
            model_bytes[int'(a[7:0]) + i] = wd[8*i +: 8];
            model_valid[int'(a[7:0]) + i] = 1'b1;
        end
    endtask

    task automatic load_check(input addr_t a, input funct3_t f3);
        logic  known;
        word_t raw;
        word_t expected;
        access(1'b0, 1'b0, a, f3, 32'h0);
        known = 1'b1;
        raw   = '0;
        for (int i = 0; i < access_bytes(f3); i++) begin
            known         = known && model_valid[int'(a[7:0]) + i];
            raw[8*i +: 8] = model_bytes[int'(a[7:0]) + i];
        end
        expected = extend(raw, f3);
        // Bytes never stored have no defined value
        if (known) begin
            assert (rd === expected) else begin
                errors++;
                $display("error: read_data at %h expected %h actual %h", a, expected, rd);
            end
        end
    endtask

    initial begin
        logic    is_store;
        funct3_t f3;
        addr_t   a;
        errors     = 0;
        hung       = 1'b0;
        reset      = 1'b1;
        addr       = '0;
        write_data = '0;
        write_en   = 1'b0;
        read_en    = 1'b0;
        bypass     = 1'b0;
        funct3     = F3_W;
        for (int i = 0; i < 256; i++) begin
            model_bytes[i] = 8'h00;
            model_valid[i] = 1'b0;
        end
        void'($urandom(32'h2d19eebe));
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // Store misses allocate, later loads hit
        store(32'h00, F3_W, 32'h1122_3344);
        store(32'h04, F3_W, 32'hdead_beef);
        load_check(32'h00, F3_W);
        check_flag("hit", first_hit, 1'b1);
        load_check(32'h04, F3_W);

        // Sub-word stores and sign or zero extension
        store(32'h08, F3_W, 32'h0000_0000);
        store(32'h08, F3_B, 32'h0000_0085);
        store(32'h09, F3_B, 32'h0000_007f);
        store(32'h0a, F3_H, 32'h0000_9abc);
        load_check(32'h08, F3_B);
        load_check(32'h08, F3_BU);
        load_check(32'h09, F3_B);
        load_check(32'h0a, F3_H);
        load_check(32'h0a, F3_HU);
        load_check(32'h08, F3_H);
        load_check(32'h08, F3_HU);
        load_check(32'h08, F3_W);

        // Three tags in set 0 force dirty evictions
        store(32'h20, F3_W, 32'h5566_7788);
        store(32'h40, F3_W, 32'hcafe_f00d);
        load_check(32'h00, F3_W);
        check_flag("hit", first_hit, 1'b0);
        load_check(32'h04, F3_W);
        load_check(32'h08, F3_W);
        load_check(32'h20, F3_W);
        load_check(32'h40, F3_W);

        // Two tags in set 1 stay resident
        store(32'h10, F3_W, 32'h0102_0304);
        store(32'h30, F3_W, 32'h0a0b_0c0d);
        for (int i = 0; i < 8; i++) begin
            load_check((i % 2 == 0) ? 32'h10 : 32'h30, F3_W);
            check_flag("hit", first_hit, 1'b1);
            check_flag("busy", first_busy, 1'b0);
        end

        // Bypassed load on a missing line
        access(1'b0, 1'b1, 32'h50, F3_W, 32'h0);
        check_flag("hit", first_hit, 1'b0);
        check_flag("busy", first_busy, 1'b0);
        for (int i = 0; i < 3; i++) begin
            check_flag("mem_req.read_en", dut_i.mem_req.read_en, 1'b0);
            check_flag("mem_req.write_en", dut_i.mem_req.write_en, 1'b0);
            @(negedge clk);
        end

        // Random mix of every access kind
        for (int k = 0; k < 400; k++) begin
            is_store = ($urandom_range(0, 1) == 1);
            f3 = is_store ? kind_of($urandom_range(0, 2)) : kind_of($urandom_range(0, 4));
            a  = ($urandom & 32'h0000_00ff) & ~32'(access_bytes(f3) - 1);
            if (is_store) begin
                store(a, f3, $urandom);
            end else begin
                load_check(a, f3);
            end
        end

        repeat (2) @(negedge clk);
        $display("check errors: %0d, assertion failures: %0d",
                 errors, dut_i.checker_i.fail_count);
        if (errors == 0 && dut_i.checker_i.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
